// ==== logic/a2_bus_pkg.sv ====
// Apple II bus types, speaker soft-switch address and text-page window constants
package a2_bus_pkg;

    // Address and data buses as seen on the slot connector
    typedef logic [15:0] a2_addr_t;
    typedef logic [7:0]  a2_data_t;

    // Speaker soft switch, any access toggles the cone
    localparam a2_addr_t SPEAKER_ADDR = 16'hC030;

    // Text page 1 window shadowed in card memory
    localparam a2_addr_t TEXT_BASE = 16'h0400;
    localparam int       TEXT_SIZE = 1024;     // Bytes

endpackage

// ==== logic/shadow_mem_pkg.sv ====
// Shadow memory address and data types, port numbering and port count
package shadow_mem_pkg;

    localparam int MEM_ADDR_W = 10;   // 1 KB of shadow RAM

    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
    typedef logic [7:0]            mem_data_t;

    // Lower port number wins arbitration
    localparam int VIDEO_PORT = 0;
    localparam int CPU_PORT   = 1;
    localparam int NUM_PORTS  = 2;

endpackage

// ==== logic/mem_port_if.sv ====
// Requester to arbiter memory port interface with requester and arbiter modports
interface mem_port_if;
    import shadow_mem_pkg::*;

    logic      req;     // Level, held until granted
    logic      we;
    mem_addr_t addr;
    mem_data_t wdata;
    logic      gnt;     // One-cycle pulse
    mem_data_t rdata;
    logic      rvalid;  // One cycle after a read grant

    modport requester (
        output req,
        output we,
        output addr,
        output wdata,
        input  gnt,
        input  rdata,
        input  rvalid
    );

    modport arbiter (
        input  req,
        input  we,
        input  addr,
        input  wdata,
        output gnt,
        output rdata,
        output rvalid
    );

endinterface

// ==== logic/bus_snoop.sv ====
// Apple bus snooper with phi1 synchronizer, cycle capture, text-window writes and speaker toggle
module bus_snoop (
    input  logic                  clk_pixel_w,
    input  logic                  system_reset_n_w,
    input  logic                  a2_phi1_i,
    input  a2_bus_pkg::a2_addr_t  a2_addr_i,
    input  a2_bus_pkg::a2_data_t  a2_data_i,
    input  logic                  a2_rw_n_i,
    input  logic                  a2_m2sel_n_i,
    mem_port_if.requester         cpu_port,
    output logic                  speaker_toggle_o
);
    import a2_bus_pkg::*;
    import shadow_mem_pkg::*;

    localparam a2_addr_t TEXT_LIMIT = a2_addr_t'(TEXT_BASE + TEXT_SIZE);

    logic     phi1_meta_r;
    logic     phi1_sync_r;
    logic     phi1_prev_r;
    logic     phi1_rise_w;

    logic     cap_valid_r;
    a2_addr_t addr_cap_r;
    a2_data_t data_cap_r;
    logic     rw_n_cap_r;
    logic     m2sel_n_cap_r;

    logic     in_window_w;
    logic     window_write_w;
    logic     speaker_hit_w;
    a2_addr_t offset_w;

    assign phi1_rise_w = phi1_sync_r & ~phi1_prev_r;

    // phi1 into the pixel clock domain, edge found one flop later
    always_ff @(posedge clk_pixel_w or negedge system_reset_n_w) begin
        if (!system_reset_n_w) begin
            phi1_meta_r <= 1'b0;
            phi1_sync_r <= 1'b0;
            phi1_prev_r <= 1'b0;
            cap_valid_r <= 1'b0;
        end else begin
            phi1_meta_r <= a2_phi1_i;
            phi1_sync_r <= phi1_meta_r;
            phi1_prev_r <= phi1_sync_r;
            cap_valid_r <= phi1_rise_w;
        end
    end

    // Bus is stable while phi1 is high
    always_ff @(posedge clk_pixel_w) begin
        if (phi1_rise_w) begin
            addr_cap_r    <= a2_addr_i;
            data_cap_r    <= a2_data_i;
            rw_n_cap_r    <= a2_rw_n_i;
            m2sel_n_cap_r <= a2_m2sel_n_i;
        end
    end

    // Decode of the captured cycle
    assign in_window_w    = (addr_cap_r >= TEXT_BASE) && (addr_cap_r < TEXT_LIMIT);
    assign window_write_w = cap_valid_r && !m2sel_n_cap_r && !rw_n_cap_r && in_window_w;
    assign speaker_hit_w  = cap_valid_r && !m2sel_n_cap_r && (addr_cap_r == SPEAKER_ADDR);
    assign offset_w       = addr_cap_r - TEXT_BASE;

    assign cpu_port.we = 1'b1;     // Snooper only ever writes

    always_ff @(posedge clk_pixel_w or negedge system_reset_n_w) begin
        if (!system_reset_n_w) begin
            cpu_port.req     <= 1'b0;
            speaker_toggle_o <= 1'b0;
        end else begin
            if (window_write_w) begin
                cpu_port.req <= 1'b1;  // Newer cycle replaces a pending one
            end else if (cpu_port.gnt) begin
                cpu_port.req <= 1'b0;
            end
            speaker_toggle_o <= speaker_hit_w;
        end
    end

    always_ff @(posedge clk_pixel_w) begin
        if (window_write_w) begin
            cpu_port.addr  <= mem_addr_t'(offset_w);
            cpu_port.wdata <= mem_data_t'(data_cap_r);
        end
    end

endmodule

// ==== logic/video_fetch.sv ====
// Video read port that issues one shadow memory read at a time and returns the byte
module video_fetch (
    input  logic                      clk_pixel_w,
    input  logic                      system_reset_n_w,
    input  logic                      video_rd_i,
    input  shadow_mem_pkg::mem_addr_t video_addr_i,
    mem_port_if.requester             vid_port,
    output logic                      video_busy_o,
    output logic                      video_valid_o,
    output shadow_mem_pkg::mem_data_t video_data_o
);

    logic accept_w;

    assign accept_w = video_rd_i && !video_busy_o;

    // Read only port
    assign vid_port.we    = 1'b0;
    assign vid_port.wdata = '0;

    always_ff @(posedge clk_pixel_w or negedge system_reset_n_w) begin
        if (!system_reset_n_w) begin
            video_busy_o  <= 1'b0;
            video_valid_o <= 1'b0;
            vid_port.req  <= 1'b0;
        end else begin
            video_valid_o <= vid_port.rvalid;
            if (accept_w) begin
                video_busy_o <= 1'b1;
                vid_port.req <= 1'b1;
            end else begin
                if (vid_port.gnt) begin
                    vid_port.req <= 1'b0;
                end
                if (vid_port.rvalid) begin
                    video_busy_o <= 1'b0;  // Drops with the valid pulse
                end
            end
        end
    end

    always_ff @(posedge clk_pixel_w) begin
        if (accept_w) begin
            vid_port.addr <= video_addr_i;
        end
        if (vid_port.rvalid) begin
            video_data_o <= vid_port.rdata;
        end
    end

endmodule

// ==== logic/shadow_memory.sv ====
// Fixed-priority two-port arbiter with 1 KB shadow RAM and read-data return
module shadow_memory (
    input  logic        clk_pixel_w,
    input  logic        system_reset_n_w,
    mem_port_if.arbiter vid_port,
    mem_port_if.arbiter cpu_port
);
    import shadow_mem_pkg::*;

    localparam int MEM_DEPTH = 2 ** MEM_ADDR_W;

    logic      [NUM_PORTS-1:0] req_w;
    logic      [NUM_PORTS-1:0] we_w;
    mem_addr_t                 addr_w  [NUM_PORTS];
    mem_data_t                 wdata_w [NUM_PORTS];

    logic      [NUM_PORTS-1:0] gnt_w;
    logic      [NUM_PORTS-1:0] last_gnt_r;
    logic      [NUM_PORTS-1:0] rvalid_r;

    logic                      sel_we_w;
    mem_addr_t                 sel_addr_w;
    mem_data_t                 sel_wdata_w;

    mem_data_t                 ram_r [MEM_DEPTH];
    mem_data_t                 rdata_r;

    // Gather the named ports into arrays by port number
    assign req_w[VIDEO_PORT]   = vid_port.req;
    assign we_w[VIDEO_PORT]    = vid_port.we;
    assign addr_w[VIDEO_PORT]  = vid_port.addr;
    assign wdata_w[VIDEO_PORT] = vid_port.wdata;

    assign req_w[CPU_PORT]   = cpu_port.req;
    assign we_w[CPU_PORT]    = cpu_port.we;
    assign addr_w[CPU_PORT]  = cpu_port.addr;
    assign wdata_w[CPU_PORT] = cpu_port.wdata;

    // Lowest requesting port wins, but never twice in a row
    always_comb begin
        gnt_w = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (req_w[i] && !last_gnt_r[i] && (gnt_w == '0)) begin
                gnt_w[i] = 1'b1;
            end
        end
    end

    // One-hot grant, so an OR-style select is enough
    always_comb begin
        sel_we_w    = 1'b0;
        sel_addr_w  = '0;
        sel_wdata_w = '0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (gnt_w[i]) begin
                sel_we_w    = we_w[i];
                sel_addr_w  = addr_w[i];
                sel_wdata_w = wdata_w[i];
            end
        end
    end

    always_ff @(posedge clk_pixel_w or negedge system_reset_n_w) begin
        if (!system_reset_n_w) begin
            last_gnt_r <= '0;
            rvalid_r   <= '0;
        end else begin
            last_gnt_r <= gnt_w;
            rvalid_r   <= gnt_w & ~we_w;   // Reads answer one cycle later
        end
    end

    // Write lands in the grant cycle
    always_ff @(posedge clk_pixel_w) begin
        if ((gnt_w != '0) && sel_we_w) begin
            ram_r[sel_addr_w] <= sel_wdata_w;
        end
        if ((gnt_w != '0) && !sel_we_w) begin
            rdata_r <= ram_r[sel_addr_w];
        end
    end

    assign vid_port.gnt    = gnt_w[VIDEO_PORT];
    assign vid_port.rvalid = rvalid_r[VIDEO_PORT];
    assign vid_port.rdata  = rdata_r;

    assign cpu_port.gnt    = gnt_w[CPU_PORT];
    assign cpu_port.rvalid = rvalid_r[CPU_PORT];
    assign cpu_port.rdata  = rdata_r;

endmodule

// ==== logic/speaker_click.sv ====
// Speaker bit, audio tick divider and bounded-length speaker pulse stretcher
module speaker_click #(
    parameter int AUDIO_TICK_DIV = 612,
    parameter int STRETCH_TICKS  = 255
) (
    input  logic clk_pixel_w,
    input  logic system_reset_n_w,
    input  logic speaker_toggle_i,
    input  logic speaker_en_i,
    output logic speaker_o
);

    localparam int DIV_W     = (AUDIO_TICK_DIV > 1) ? $clog2(AUDIO_TICK_DIV) : 1;
    localparam int STRETCH_W = (STRETCH_TICKS > 0) ? $clog2(STRETCH_TICKS + 1) : 1;

    logic [DIV_W-1:0]     div_cnt_r;
    logic                 tick_r;
    logic                 speaker_bit_r;
    logic                 prev_bit_r;
    logic [STRETCH_W-1:0] stretch_cnt_r;

    always_ff @(posedge clk_pixel_w or negedge system_reset_n_w) begin
        if (!system_reset_n_w) begin
            div_cnt_r     <= '0;
            tick_r        <= 1'b0;
            speaker_bit_r <= 1'b0;
            prev_bit_r    <= 1'b0;
            stretch_cnt_r <= '0;
            speaker_o     <= 1'b0;
        end else begin
            // One tick every AUDIO_TICK_DIV clocks
            if (div_cnt_r == DIV_W'(AUDIO_TICK_DIV - 1)) begin
                div_cnt_r <= '0;
                tick_r    <= 1'b1;
            end else begin
                div_cnt_r <= div_cnt_r + 1'b1;
                tick_r    <= 1'b0;
            end

            if (speaker_toggle_i) begin
                speaker_bit_r <= ~speaker_bit_r;
            end

            // A held level must not sit on the audio line forever
            if (tick_r) begin
                if (speaker_bit_r != prev_bit_r) begin
                    stretch_cnt_r <= STRETCH_W'(STRETCH_TICKS);
                end else if (stretch_cnt_r != '0) begin
                    stretch_cnt_r <= stretch_cnt_r - 1'b1;
                end
                prev_bit_r <= speaker_bit_r;
                speaker_o  <= prev_bit_r && (stretch_cnt_r != '0) && speaker_en_i;
            end
        end
    end

endmodule

// ==== logic/a2_shadow_top.sv ====
// Top level wiring bus snooper, video fetcher, shadow memory and speaker logic
module a2_shadow_top #(
    parameter int AUDIO_TICK_DIV = 612,   // About 44.1 kHz at 27 MHz
    parameter int STRETCH_TICKS  = 255
) (
    input  logic                      clk_pixel_w,
    input  logic                      system_reset_n_w,

    // Apple bus
    input  logic                      a2_phi1_i,
    input  a2_bus_pkg::a2_addr_t      a2_addr_i,
    input  a2_bus_pkg::a2_data_t      a2_data_i,
    input  logic                      a2_rw_n_i,
    input  logic                      a2_m2sel_n_i,

    input  logic                      speaker_en_i,

    // Video read port
    input  logic                      video_rd_i,
    input  shadow_mem_pkg::mem_addr_t video_addr_i,
    output logic                      video_busy_o,
    output logic                      video_valid_o,
    output shadow_mem_pkg::mem_data_t video_data_o,

    output logic                      speaker_o
);

    logic speaker_toggle_w;

    mem_port_if vid_port ();   // Port 0, highest priority
    mem_port_if cpu_port ();   // Port 1

    bus_snoop bus_snoop0 (
        .clk_pixel_w      (clk_pixel_w),
        .system_reset_n_w (system_reset_n_w),
        .a2_phi1_i        (a2_phi1_i),
        .a2_addr_i        (a2_addr_i),
        .a2_data_i        (a2_data_i),
        .a2_rw_n_i        (a2_rw_n_i),
        .a2_m2sel_n_i     (a2_m2sel_n_i),
        .cpu_port         (cpu_port),
        .speaker_toggle_o (speaker_toggle_w)
    );

    video_fetch video_fetch0 (
        .clk_pixel_w      (clk_pixel_w),
        .system_reset_n_w (system_reset_n_w),
        .video_rd_i       (video_rd_i),
        .video_addr_i     (video_addr_i),
        .vid_port         (vid_port),
        .video_busy_o     (video_busy_o),
        .video_valid_o    (video_valid_o),
        .video_data_o     (video_data_o)
    );

    shadow_memory shadow_memory0 (
        .clk_pixel_w      (clk_pixel_w),
        .system_reset_n_w (system_reset_n_w),
        .vid_port         (vid_port),
        .cpu_port         (cpu_port)
    );

    speaker_click #(
        .AUDIO_TICK_DIV (AUDIO_TICK_DIV),
        .STRETCH_TICKS  (STRETCH_TICKS)
    ) speaker_click0 (
        .clk_pixel_w      (clk_pixel_w),
        .system_reset_n_w (system_reset_n_w),
        .speaker_toggle_i (speaker_toggle_w),
        .speaker_en_i     (speaker_en_i),
        .speaker_o        (speaker_o)
    );

endmodule

// ==== testbench/tb_clock_gen.sv ====
// Testbench clock and reset generator
module tb_clock_gen #(
    parameter int PERIOD       = 20,
    parameter int RESET_CYCLES = 2
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // Reset low for the first rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

// ==== testbench/a2_shadow_sva.sv ====
// Arbiter grant and video read latency assertions bound to the shadow top level
module a2_shadow_sva (
    input logic clk_pixel_w,
    input logic system_reset_n_w,
    input logic vid_req_i,
    input logic vid_gnt_i,
    input logic cpu_req_i,
    input logic cpu_gnt_i,
    input logic video_rd_i,
    input logic video_busy_i,
    input logic video_valid_i
);

    a_single_grant: assert property (@(posedge clk_pixel_w) disable iff (!system_reset_n_w)
        !(vid_gnt_i && cpu_gnt_i))
        else $error("both memory ports granted in the same cycle");

    a_grant_with_req: assert property (@(posedge clk_pixel_w) disable iff (!system_reset_n_w)
        (!vid_gnt_i || vid_req_i) && (!cpu_gnt_i || cpu_req_i))
        else $error("grant on a port that is not requesting");

    // Valid is set two clocks after the accepting edge and sampled one edge later
    a_video_latency: assert property (@(posedge clk_pixel_w) disable iff (!system_reset_n_w)
        video_valid_i == $past(video_rd_i && !video_busy_i, 3))
        else $error("video valid not two clocks after an accepted read");

endmodule

bind a2_shadow_top a2_shadow_sva sva0 (
    .clk_pixel_w      (clk_pixel_w),
    .system_reset_n_w (system_reset_n_w),
    .vid_req_i        (vid_port.req),
    .vid_gnt_i        (vid_port.gnt),
    .cpu_req_i        (cpu_port.req),
    .cpu_gnt_i        (cpu_port.gnt),
    .video_rd_i       (video_rd_i),
    .video_busy_i     (video_busy_o),
    .video_valid_i    (video_valid_o)
);

// ==== testbench/tb_top.sv ====
// Testbench top running golden-vector Apple bus cycles, video reads and speaker checks
module tb_top;
    import a2_bus_pkg::*;
    import shadow_mem_pkg::*;

    localparam string VECTOR_FILE  = "testbench/golden_vectors.txt";
    localparam int    READ_TIMEOUT = 20;

    logic      clk_pixel_w;
    logic      system_reset_n_w;
    logic      a2_phi1_i;
    a2_addr_t  a2_addr_i;
    a2_data_t  a2_data_i;
    logic      a2_rw_n_i;
    logic      a2_m2sel_n_i;
    logic      speaker_en_i;
    logic      video_rd_i;
    mem_addr_t video_addr_i;
    logic      video_busy_o;
    logic      video_valid_o;
    mem_data_t video_data_o;
    logic      speaker_o;

    logic [7:0] lfsr_state;
    logic       have_last;    // Offset with a verified byte, used by overlapping reads
    mem_addr_t  last_off;
    mem_data_t  last_val;

    tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(2)) clock_gen0 (
        .clk_o   (clk_pixel_w),
        .rst_n_o (system_reset_n_w)
    );

    a2_shadow_top #(.AUDIO_TICK_DIV(8)) dut0 (.*);

    task automatic abort_run();
        $display("test failed");
        $fatal(1, "stopped at the first error");
    endtask

    // Galois LFSR, one step per bit taken
    function automatic logic [7:0] take_bits(input int count);
        logic [7:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits = {bits[6:0], lfsr_state[0]};
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 8'hB8) : (lfsr_state >> 1);
        end
        return bits;
    endfunction

    task automatic video_read(input mem_addr_t offset, input mem_data_t expected);
        int waits;
        @(posedge clk_pixel_w);
        video_rd_i   <= 1'b1;
        video_addr_i <= offset;
        @(posedge clk_pixel_w);    // Accepting edge
        video_rd_i <= 1'b0;
        waits = 0;
        do begin
            @(negedge clk_pixel_w);
            waits++;
            // Busy from the accepting edge until valid
            assert (video_busy_o === !video_valid_o) else begin
                $display("error at %0t: video_busy_o is %b while video_valid_o is %b",
                         $time, video_busy_o, video_valid_o);
                abort_run();
            end
        end while (!video_valid_o && waits < READ_TIMEOUT);
        assert (video_valid_o) else begin
            $display("video read of offset %h never returned valid", offset);
            abort_run();
        end
        assert (waits == 3 && video_data_o === expected) else begin
            $display("error at %0t: offset %h gave %h after %0d clocks, expected %h after 2",
                     $time, offset, video_data_o, waits - 1, expected);
            abort_run();
        end
    endtask

    // Phi1 high for 4 clocks then low for 4, with an optional read in the high phase
    task automatic apple_cycle(input a2_addr_t addr, input a2_data_t data,
                               input logic rw_n, input logic m2sel_n);
        logic [7:0] gap;
        logic [7:0] pick;
        logic       overlap;
        gap     = take_bits(3);
        pick    = take_bits(1);
        overlap = pick[0] && have_last;
        repeat (gap) @(posedge clk_pixel_w);
        @(posedge clk_pixel_w);
        a2_addr_i    <= addr;
        a2_data_i    <= data;
        a2_rw_n_i    <= rw_n;
        a2_m2sel_n_i <= m2sel_n;
        a2_phi1_i    <= 1'b1;
        fork
            begin
                repeat (4) @(posedge clk_pixel_w);
                a2_phi1_i <= 1'b0;
                repeat (4) @(posedge clk_pixel_w);
            end
            begin
                if (overlap) begin
                    repeat (2) @(posedge clk_pixel_w);   // Video request meets the write request
                    video_read(last_off, last_val);
                end
            end
        join
    endtask

    // Wait for a speaker level, or with hold set check it on every clock
    task automatic speaker_check(input logic level, input int clocks, input logic hold);
        int waits;
        waits = 0;
        do begin
            @(negedge clk_pixel_w);
            waits++;
            assert (!hold || speaker_o === level) else begin
                $display("error at %0t: speaker_o is %b, expected to hold %b", $time, speaker_o,
                         level);
                abort_run();
            end
        end while (waits < clocks && (hold || speaker_o !== level));
        assert (speaker_o === level) else begin
            $display("speaker_o did not reach %b within %0d clocks", level, clocks);
            abort_run();
        end
    endtask

    initial begin
        int          fd;
        int          count;
        string       line;
        byte         cmd;
        logic [31:0] f [4];
        a2_addr_t    addr;
        a2_phi1_i    <= 1'b0;
        a2_addr_i    <= '0;
        a2_data_i    <= '0;
        a2_rw_n_i    <= 1'b1;
        a2_m2sel_n_i <= 1'b1;
        speaker_en_i <= 1'b0;
        video_rd_i   <= 1'b0;
        video_addr_i <= '0;
        lfsr_state = 8'd15;
        have_last  = 1'b0;
        count      = 0;
        for (int i = 0; i < 10 && !system_reset_n_w; i++) begin
            @(posedge clk_pixel_w);
        end
        assert (system_reset_n_w) else begin
            $display("reset was never released");
            abort_run();
        end
        fd = $fopen(VECTOR_FILE, "r");
        assert (fd != 0) else begin
            $display("could not open the vector file %s", VECTOR_FILE);
            abort_run();
        end
        while ($fgets(line, fd) != 0) begin
            cmd = (line.len() > 0) ? line.getc(0) : "#";
            if (cmd inside {"#", "\n", " "}) begin
                continue;
            end
            void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", f[0], f[1], f[2], f[3]));
            count++;
            case (cmd)
                "W": begin
                    addr = a2_addr_t'(f[0]);
                    if (!f[2][0] && !f[3][0] && addr >= TEXT_BASE && addr < TEXT_BASE + TEXT_SIZE
                        && mem_addr_t'(addr - TEXT_BASE) == last_off) begin
                        have_last = 1'b0;   // Byte about to change
                    end
                    apple_cycle(addr, a2_data_t'(f[1]), f[2][0], f[3][0]);
                end
                "A": apple_cycle(a2_addr_t'(f[0]), 8'h00, 1'b1, 1'b0);
                "R": begin
                    repeat (8) @(posedge clk_pixel_w);
                    last_off = mem_addr_t'(f[0]);
                    last_val = mem_data_t'(f[1]);
                    video_read(last_off, last_val);
                    have_last = 1'b1;
                end
                "E": begin
                    @(posedge clk_pixel_w);
                    speaker_en_i <= f[0][0];
                end
                "K": speaker_check(f[0][0], int'(f[1]), 1'b0);
                "S": speaker_check(f[0][0], int'(f[1]), 1'b1);
                default: begin
                    $display("unknown command in vector line %s", line);
                    abort_run();
                end
            endcase
        end
        $fclose(fd);
        assert (count > 0) else begin
            $display("the vector file held no commands");
            abort_run();
        end
        $display("test passed");
        $finish;
    end

endmodule

// ==== testbench/golden_vectors.txt ====
# W addr data rw_n m2sel_n | A addr | R offset expected | E speaker_en
# K level max_clocks | S level clocks    all fields hex
W 0400 41 0 0
R 000 41
W 07FF 5A 0 0
R 3FF 5A
W 0410 77 0 0
W 0410 99 0 1
W 0410 98 1 0
W 0810 97 0 0
R 010 77
R 000 41
W 05A5 C3 0 0
W 0600 3C 0 0
W 0401 E7 0 0
R 1A5 C3
R 200 3C
R 001 E7
E 1
A C030
K 1 28
K 0 BB8
A C030
E 0
A C030
S 0 190

// ==== project.f ====
logic/a2_bus_pkg.sv
logic/shadow_mem_pkg.sv
logic/mem_port_if.sv
logic/bus_snoop.sv
logic/video_fetch.sv
logic/shadow_memory.sv
logic/speaker_click.sv
logic/a2_shadow_top.sv
testbench/tb_clock_gen.sv
testbench/a2_shadow_sva.sv
testbench/tb_top.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f project.f -o sim_top &&
./obj_dir/sim_top | grep "^test passed$" || { echo "simulation did not pass"; exit 1; }
